/* hw/pmp_pkg.sv */
////////////////////////////////////////
// Shared types for the PMP unit
// Address widths, mode and privilege encodings,
// the software configuration byte and the decoded rule
// Referenced by scoped names from every RTL file
////////////////////////////////////////

package pmp_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   // Byte address width of the core
   localparam int unsigned XLEN   = 32;

   // Word address width, byte address without bits 1:0
   localparam int unsigned WORD_W = XLEN - 2;

   typedef logic [XLEN-1:0]   pmp_addr_t;
   typedef logic [WORD_W-1:0] pmp_word_t;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Address matching mode, as held in cfg bits 4:3
   typedef enum logic [1:0]
   {
      PMP_OFF   = 2'd0,
      PMP_TOR   = 2'd1,
      PMP_NA4   = 2'd2,
      PMP_NAPOT = 2'd3
   } pmp_mode_e;

   // Privilege of the current access
   typedef enum logic
   {
      PRIV_USER    = 1'b0,
      PRIV_MACHINE = 1'b1
   } pmp_priv_e;

   ////////////////////////////////////////
   // Configuration and rules
   ////////////////////////////////////////

   // One pmpcfg byte, standard layout
   typedef struct packed
   {
      logic       lock;
      logic [1:0] reserved;
      pmp_mode_e  mode;
      logic       x;
      logic       w;
      logic       r;
   } pmp_cfg_t;

   // Decoded rule, all addresses in words
   // Top is only meaningful for TOR, mask only for NAPOT
   typedef struct packed
   {
      logic      enable;
      pmp_mode_e mode;
      logic      r;
      logic      w;
      logic      x;
      pmp_word_t base;
      pmp_word_t top;
      pmp_word_t mask;
   } pmp_rule_t;

endpackage

/* hw/pmp_rule_table.sv */
////////////////////////////////////////
// PMP rule table
// Decodes each cfg byte and address word into a rule
// and registers the table for both port checkers
// A configuration change shows up one clock later
////////////////////////////////////////

`timescale 1ns/1ps

module pmp_rule_table
#(
   parameter int unsigned N_PMP_ENTRIES = 16
)
(
   input  logic                                        clk,
   input  logic                                        rst_n_i,

   input  pmp_pkg::pmp_word_t [N_PMP_ENTRIES-1:0]      pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t  [N_PMP_ENTRIES-1:0]      pmp_cfg_i,

   output pmp_pkg::pmp_rule_t [N_PMP_ENTRIES-1:0]      rules_o
);

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Length of the run of ones starting at bit 0
   function automatic logic [4:0] trailing_ones(input pmp_pkg::pmp_word_t a);
      logic [4:0] n;
      logic       run;
      n   = '0;
      run = 1'b1;
      for (int b = 0; b < pmp_pkg::WORD_W; b++)
      begin
         if (run && a[b])
         begin
            n = n + 5'd1;
         end
         else
         begin
            run = 1'b0;
         end
      end
      return n;
   endfunction

   // Clears bits 0 up to and including the zero that ends the run
   function automatic pmp_pkg::pmp_word_t napot_mask(input logic [4:0] ones);
      pmp_pkg::pmp_word_t m;
      m = '0;
      for (int b = 0; b < pmp_pkg::WORD_W; b++)
      begin
         m[b] = (b > int'(ones));
      end
      return m;
   endfunction

   ////////////////////////////////////////
   // Per entry decode and register
   ////////////////////////////////////////

   for (genvar i = 0; i < N_PMP_ENTRIES; i++)
   begin : g_entry
      pmp_pkg::pmp_word_t tor_base;
      pmp_pkg::pmp_word_t mask;
      logic [4:0]         ones;
      pmp_pkg::pmp_rule_t rule_d;
      pmp_pkg::pmp_rule_t rule_q;

      // TOR range starts at the previous entry, entry 0 at address 0
      if (i == 0)
      begin : g_first
         assign tor_base = '0;
      end
      else
      begin : g_next
         assign tor_base = pmp_addr_i[i-1];
      end

      assign ones = trailing_ones(pmp_addr_i[i]);
      assign mask = napot_mask(ones);

      always_comb
      begin
         rule_d      = '0;
         rule_d.mode = pmp_cfg_i[i].mode;
         rule_d.r    = pmp_cfg_i[i].r;
         rule_d.w    = pmp_cfg_i[i].w;
         rule_d.x    = pmp_cfg_i[i].x;

         case (pmp_cfg_i[i].mode)
            pmp_pkg::PMP_OFF:
            begin
               rule_d.enable = 1'b0;
            end
            pmp_pkg::PMP_TOR:
            begin
               rule_d.enable = 1'b1;
               rule_d.base   = tor_base;
               rule_d.top    = pmp_addr_i[i];
            end
            pmp_pkg::PMP_NA4:
            begin
               rule_d.enable = 1'b1;
               rule_d.base   = pmp_addr_i[i];
            end
            pmp_pkg::PMP_NAPOT:
            begin
               // An all-ones address has no terminating zero
               rule_d.enable = (ones != 5'(pmp_pkg::WORD_W));
               rule_d.mask   = mask;
               rule_d.base   = pmp_addr_i[i] & mask;
            end
            default:
            begin
               rule_d.enable = 1'b0;
            end
         endcase
      end

      always_ff @(posedge clk or negedge rst_n_i)
      begin
         if (!rst_n_i)
         begin
            rule_q <= '0;
         end
         else
         begin
            rule_q <= rule_d;
         end
      end

      assign rules_o[i] = rule_q;
   end

endmodule

/* hw/pmp_port_check.sv */
////////////////////////////////////////
// PMP port checker
// Matches one port's address against the rule table
// and forwards or refuses the request in the same cycle
////////////////////////////////////////

`timescale 1ns/1ps

module pmp_port_check
#(
   parameter int unsigned N_PMP_ENTRIES = 16
)
(
   input  pmp_pkg::pmp_rule_t [N_PMP_ENTRIES-1:0]      rules_i,
   // Permission bit per entry for this access type
   input  logic               [N_PMP_ENTRIES-1:0]      perm_i,
   input  pmp_pkg::pmp_priv_e                          priv_i,

   // Core side
   input  logic                                        req_i,
   input  pmp_pkg::pmp_addr_t                          addr_i,
   output logic                                        gnt_o,

   // Memory side
   output logic                                        req_o,
   input  logic                                        gnt_i,
   output pmp_pkg::pmp_addr_t                          addr_o,
   output logic                                        err_o
);

   pmp_pkg::pmp_word_t         word;
   logic [N_PMP_ENTRIES-1:0]   match;
   logic                       allowed;

   // Rules work on word addresses
   assign word = addr_i[pmp_pkg::XLEN-1:2];

   ////////////////////////////////////////
   // Region match
   ////////////////////////////////////////

   always_comb
   begin
      for (int j = 0; j < N_PMP_ENTRIES; j++)
      begin
         match[j] = 1'b0;
         if (rules_i[j].enable && perm_i[j])
         begin
            case (rules_i[j].mode)
               pmp_pkg::PMP_TOR:
               begin
                  // Base inclusive, top exclusive
                  match[j] = (word >= rules_i[j].base) && (word < rules_i[j].top);
               end
               pmp_pkg::PMP_NA4:
               begin
                  match[j] = (word == rules_i[j].base);
               end
               pmp_pkg::PMP_NAPOT:
               begin
                  match[j] = ((word & rules_i[j].mask) == rules_i[j].base);
               end
               default:
               begin
                  match[j] = 1'b0;
               end
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // Request gate
   ////////////////////////////////////////

   // Machine mode skips the check entirely
   assign allowed = (priv_i == pmp_pkg::PRIV_MACHINE) || (|match);

   always_comb
   begin
      if (allowed)
      begin
         req_o = req_i;
         gnt_o = gnt_i;
         err_o = 1'b0;
      end
      else
      begin
         req_o = 1'b0;
         gnt_o = 1'b0;
         err_o = req_i;
      end
   end

   assign addr_o = addr_i;

endmodule

/* hw/riscv_pmp.sv */
////////////////////////////////////////
// Physical memory protection, top level
// Sits between the core and memory on the data
// and fetch ports, refusing accesses that no rule allows
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_pmp
#(
   parameter int unsigned N_PMP_ENTRIES = 16
)
(
   input  logic                                        clk,
   input  logic                                        rst_n_i,

   // 0 is user, 1 is machine
   input  logic                                        pmp_privil_mode_i,

   input  pmp_pkg::pmp_word_t [N_PMP_ENTRIES-1:0]      pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t  [N_PMP_ENTRIES-1:0]      pmp_cfg_i,

   // Data side, core
   input  logic                                        data_req_i,
   input  pmp_pkg::pmp_addr_t                          data_addr_i,
   input  logic                                        data_we_i,
   output logic                                        data_gnt_o,
   // Data side, memory
   output logic                                        data_req_o,
   input  logic                                        data_gnt_i,
   output pmp_pkg::pmp_addr_t                          data_addr_o,
   output logic                                        data_err_o,

   // Fetch side, core
   input  logic                                        instr_req_i,
   input  pmp_pkg::pmp_addr_t                          instr_addr_i,
   output logic                                        instr_gnt_o,
   // Fetch side, memory
   output logic                                        instr_req_o,
   input  logic                                        instr_gnt_i,
   output pmp_pkg::pmp_addr_t                          instr_addr_o,
   output logic                                        instr_err_o
);

   pmp_pkg::pmp_rule_t [N_PMP_ENTRIES-1:0]   rules;
   logic               [N_PMP_ENTRIES-1:0]   data_perm;
   logic               [N_PMP_ENTRIES-1:0]   instr_perm;
   pmp_pkg::pmp_priv_e                       priv;

   assign priv = pmp_pkg::pmp_priv_e'(pmp_privil_mode_i);

   pmp_rule_table
   #(
      .N_PMP_ENTRIES (N_PMP_ENTRIES)
   )
   u_rule_table
   (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .pmp_addr_i (pmp_addr_i),
      .pmp_cfg_i  (pmp_cfg_i),
      .rules_o    (rules)
   );

   // Stores need W, loads need R, fetches need X
   always_comb
   begin
      for (int j = 0; j < N_PMP_ENTRIES; j++)
      begin
         data_perm[j]  = data_we_i ? rules[j].w : rules[j].r;
         instr_perm[j] = rules[j].x;
      end
   end

   pmp_port_check
   #(
      .N_PMP_ENTRIES (N_PMP_ENTRIES)
   )
   u_data_check
   (
      .rules_i (rules),
      .perm_i  (data_perm),
      .priv_i  (priv),
      .req_i   (data_req_i),
      .addr_i  (data_addr_i),
      .gnt_o   (data_gnt_o),
      .req_o   (data_req_o),
      .gnt_i   (data_gnt_i),
      .addr_o  (data_addr_o),
      .err_o   (data_err_o)
   );

   pmp_port_check
   #(
      .N_PMP_ENTRIES (N_PMP_ENTRIES)
   )
   u_instr_check
   (
      .rules_i (rules),
      .perm_i  (instr_perm),
      .priv_i  (priv),
      .req_i   (instr_req_i),
      .addr_i  (instr_addr_i),
      .gnt_o   (instr_gnt_o),
      .req_o   (instr_req_o),
      .gnt_i   (instr_gnt_i),
      .addr_o  (instr_addr_o),
      .err_o   (instr_err_o)
   );

endmodule

/* verification/riscv_pmp_chk.sv */
////////////////////////////////////////
// Concurrent checks on the PMP top level
// Bound into riscv_pmp from the testbench
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_pmp_chk
(
   input logic                clk,
   input logic                rst_n_i,
   input logic                pmp_privil_mode_i,
   input logic                data_req_i,
   input logic                data_req_o,
   input logic                data_err_o,
   input pmp_pkg::pmp_addr_t  data_addr_i,
   input pmp_pkg::pmp_addr_t  data_addr_o,
   input logic                instr_req_i,
   input logic                instr_req_o,
   input logic                instr_err_o,
   input pmp_pkg::pmp_addr_t  instr_addr_i,
   input pmp_pkg::pmp_addr_t  instr_addr_o
);

   // A refused request never reaches memory
   a_data_err_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      data_err_o |-> !data_req_o) else $error("data error with request forwarded");
   a_instr_err_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      instr_err_o |-> !instr_req_o) else $error("fetch error with request forwarded");

   // Errors only answer a live request
   a_data_err_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      data_err_o |-> data_req_i) else $error("data error without request");
   a_instr_err_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      instr_err_o |-> instr_req_i) else $error("fetch error without request");

   // Machine mode bypasses every rule
   a_machine_no_err: assert property (@(posedge clk) disable iff (!rst_n_i)
      pmp_privil_mode_i |-> !(data_err_o || instr_err_o))
      else $error("error raised in machine mode");

   a_addr_pass: assert property (@(posedge clk) disable iff (!rst_n_i)
      (data_addr_o == data_addr_i) && (instr_addr_o == instr_addr_i))
      else $error("address not passed through");

endmodule

/* verification/riscv_pmp_tb.sv */
////////////////////////////////////////
// Testbench for the PMP unit
// Seeded random traffic on both ports against a
// behavioural model of the rule table
////////////////////////////////////////

`timescale 1ns/1ps

module riscv_pmp_tb;

   localparam int N_PMP_ENTRIES = 8;
   localparam int N_TESTS       = 7;
   localparam int ITERS         = 200;
   localparam int WATCHDOG_NS   = N_TESTS * ITERS * 4 * 2;

   // Table setups
   localparam int SETUP_OFF   = 0;
   localparam int SETUP_NA4   = 1;
   localparam int SETUP_TOR   = 2;
   localparam int SETUP_NAPOT = 3;
   localparam int SETUP_MIXED = 4;

   logic clk;
   logic rst_n;
   logic priv_mode;
   pmp_pkg::pmp_word_t [N_PMP_ENTRIES-1:0] pmp_addr;
   pmp_pkg::pmp_cfg_t  [N_PMP_ENTRIES-1:0] pmp_cfg;
   logic data_req, data_we, data_gnt, data_req_mem, data_gnt_mem, data_err;
   logic instr_req, instr_gnt, instr_req_mem, instr_gnt_mem, instr_err;
   pmp_pkg::pmp_addr_t data_addr, data_addr_mem, instr_addr, instr_addr_mem;

   // Model copy of the table, one rising edge behind the inputs
   pmp_pkg::pmp_word_t [N_PMP_ENTRIES-1:0] model_addr;
   pmp_pkg::pmp_cfg_t  [N_PMP_ENTRIES-1:0] model_cfg;

   integer seed;
   int     checks;
   int     errors;
   int     test_errors;
   int     tests_failed;
   int     gnt_hold;

   riscv_pmp #(.N_PMP_ENTRIES(N_PMP_ENTRIES)) dut
   (
      .clk (clk), .rst_n_i (rst_n), .pmp_privil_mode_i (priv_mode),
      .pmp_addr_i (pmp_addr), .pmp_cfg_i (pmp_cfg),
      .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
      .data_gnt_o (data_gnt), .data_req_o (data_req_mem), .data_gnt_i (data_gnt_mem),
      .data_addr_o (data_addr_mem), .data_err_o (data_err),
      .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
      .instr_req_o (instr_req_mem), .instr_gnt_i (instr_gnt_mem),
      .instr_addr_o (instr_addr_mem), .instr_err_o (instr_err)
   );

   bind riscv_pmp riscv_pmp_chk u_chk (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         model_cfg  <= '0;
         model_addr <= '0;
      end
      else
      begin
         model_cfg  <= pmp_cfg;
         model_addr <= pmp_addr;
      end
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Region test on 64-bit word addresses, so NAPOT tops never wrap
   function automatic logic entry_match(input int k, input pmp_pkg::pmp_word_t word);
      longint unsigned w;
      longint unsigned own;
      longint unsigned prev;
      longint unsigned size;
      longint unsigned base;
      int              t;
      w    = {34'd0, word};
      own  = {34'd0, model_addr[k]};
      prev = 64'd0;
      if (k > 0)
         prev = {34'd0, model_addr[k-1]};
      case (model_cfg[k].mode)
         pmp_pkg::PMP_TOR:
            return (w >= prev) && (w < own);
         pmp_pkg::PMP_NA4:
            return w == own;
         pmp_pkg::PMP_NAPOT:
         begin
            t = 0;
            while ((t < int'(pmp_pkg::WORD_W)) && model_addr[k][t])
               t++;
            if (t == int'(pmp_pkg::WORD_W))
               return 1'b0;
            size = 64'd1 << (t + 1);
            base = own & ~(size - 64'd1);
            return (w >= base) && (w < base + size);
         end
         default:
            return 1'b0;
      endcase
   endfunction

   function automatic logic access_allowed(input pmp_pkg::pmp_word_t word,
                                           input logic fetch, input logic we, input logic priv);
      logic perm;
      if (priv)
         return 1'b1;
      for (int k = 0; k < N_PMP_ENTRIES; k++)
      begin
         perm = fetch ? model_cfg[k].x : (we ? model_cfg[k].w : model_cfg[k].r);
         if (perm && entry_match(k, word))
            return 1'b1;
      end
      return 1'b0;
   endfunction

   ////////////////////////////////////////
   // Stimulus and compare
   ////////////////////////////////////////

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         test_errors++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input pmp_pkg::pmp_addr_t got,
                             input pmp_pkg::pmp_addr_t exp);
      checks++;
      if (got !== exp)
      begin
         test_errors++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_ports();
      logic d_ok;
      logic i_ok;
      d_ok = access_allowed(data_addr[31:2], 1'b0, data_we, priv_mode);
      i_ok = access_allowed(instr_addr[31:2], 1'b1, 1'b0, priv_mode);
      check_bit("data_req_o", data_req_mem, d_ok & data_req);
      check_bit("data_gnt_o", data_gnt, d_ok & data_gnt_mem);
      check_bit("data_err_o", data_err, !d_ok & data_req);
      check_addr("data_addr_o", data_addr_mem, data_addr);
      check_bit("instr_req_o", instr_req_mem, i_ok & instr_req);
      check_bit("instr_gnt_o", instr_gnt, i_ok & instr_gnt_mem);
      check_bit("instr_err_o", instr_err, !i_ok & instr_req);
      check_addr("instr_addr_o", instr_addr_mem, instr_addr);
   endtask

   // Mostly addresses close to or inside a configured region
   function automatic pmp_pkg::pmp_addr_t rand_addr();
      logic [31:0]        r;
      logic [31:0]        s;
      pmp_pkg::pmp_word_t w;
      pmp_pkg::pmp_word_t lowm;
      r = $random(seed);
      s = $random(seed);
      w = pmp_addr[int'(s[7:0]) % N_PMP_ENTRIES];
      lowm = (30'd1 << s[16:12]) - 30'd1;
      if (r[1:0] == 2'd0)
         w = r[31:2];
      else if (r[1:0] == 2'd1)
         w = w + {{26{s[11]}}, s[11:8]};
      else if (r[1:0] == 2'd2)
         w = (w & ~lowm) | (r[31:2] & lowm);
      return {w, s[31:30]};
   endfunction

   task automatic configure(input int setup);
      logic [31:0]        r;
      pmp_pkg::pmp_word_t cur;
      pmp_pkg::pmp_word_t ones;
      int                 t;
      cur = {10'd0, 20'($random(seed))};
      for (int k = 0; k < N_PMP_ENTRIES; k++)
      begin
         r = $random(seed);
         pmp_cfg[k] = '{lock: 1'b0, reserved: 2'b00, mode: pmp_pkg::pmp_mode_e'(r[1:0]),
                        x: r[4], w: r[3], r: r[2]};
         pmp_addr[k] = pmp_pkg::pmp_word_t'($random(seed));
         if (setup == SETUP_OFF)
            pmp_cfg[k].mode = pmp_pkg::PMP_OFF;
         else if (setup == SETUP_NA4)
            pmp_cfg[k].mode = pmp_pkg::PMP_NA4;
         else if (setup == SETUP_TOR)
         begin
            // Ascending tops, so each range is non-empty
            cur = cur + {8'd0, r[31:10]} + 30'd1;
            pmp_cfg[k].mode = pmp_pkg::PMP_TOR;
            pmp_addr[k] = cur;
         end
         else if (setup == SETUP_NAPOT)
         begin
            t = (k == 0) ? 0 : ((k == 1) ? 28 : int'(r[9:5] % 5'd21));
            ones = (30'd1 << t) - 30'd1;
            pmp_cfg[k].mode = pmp_pkg::PMP_NAPOT;
            pmp_addr[k] = (pmp_addr[k] & ~((ones << 1) | 30'd1)) | ones;
            // Entry 2 has no terminating zero and stays disabled
            if (k == 2)
               pmp_addr[k] = '1;
         end
      end
   endtask

   // One cycle of random core and memory traffic on both ports
   task automatic drive_traffic(input logic user_only, input logic [31:0] r);
      priv_mode = user_only ? 1'b0 : r[5];
      data_req  = r[6];
      data_we   = r[7];
      instr_req = r[8];
      // Memory grant held low in stretches
      if (gnt_hold > 0)
         gnt_hold--;
      else if (r[15:13] == 3'd0)
         gnt_hold = int'(r[18:16]);
      data_gnt_mem  = (gnt_hold == 0) && r[9];
      instr_gnt_mem = (gnt_hold == 0) && r[10];
      data_addr  = rand_addr();
      instr_addr = rand_addr();
   endtask

   task automatic report_test(input string name);
      if (test_errors != 0)
         tests_failed++;
      errors = errors + test_errors;
      $display("%-12s %0d errors", name, test_errors);
   endtask

   task automatic run_test(input string name, input int setup, input logic user_only,
                           input logic reconfig);
      logic [31:0] r;
      test_errors = 0;
      @(negedge clk);
      configure(setup);
      @(negedge clk);
      for (int it = 0; it < ITERS; it++)
      begin
         r = $random(seed);
         if (reconfig && (r[4:0] == 5'd0))
            configure(setup);
         drive_traffic(user_only, r);
         #1;
         check_ports();
         @(negedge clk);
      end
      report_test(name);
   endtask

   initial
   begin
      seed = 92;
      checks = 0;
      errors = 0;
      tests_failed = 0;
      test_errors = 0;
      gnt_hold = 0;
      rst_n = 1'b0;
      priv_mode = 1'b0;
      pmp_addr = '0;
      pmp_cfg = '0;
      {data_req, data_we, data_gnt_mem, instr_req, instr_gnt_mem} = '0;
      data_addr = '0;
      instr_addr = '0;

      // Enabled rules on the inputs, which the table held in reset must ignore
      configure(SETUP_NAPOT);
      repeat (3)
      begin
         @(negedge clk);
         drive_traffic(1'b0, $random(seed));
         #1;
         check_ports();
      end
      @(negedge clk);
      rst_n = 1'b1;
      report_test("reset");

      run_test("off", SETUP_OFF, 1'b0, 1'b0);
      run_test("na4", SETUP_NA4, 1'b1, 1'b0);
      run_test("tor", SETUP_TOR, 1'b1, 1'b0);
      run_test("napot", SETUP_NAPOT, 1'b1, 1'b0);
      run_test("fetch", SETUP_MIXED, 1'b1, 1'b0);
      run_test("passthrough", SETUP_MIXED, 1'b0, 1'b1);

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               N_TESTS, tests_failed, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* verilog.f */
hw/pmp_pkg.sv
hw/pmp_rule_table.sv
hw/pmp_port_check.sv
hw/riscv_pmp.sv
verification/riscv_pmp_chk.sv
verification/riscv_pmp_tb.sv

/* Makefile */
# Verilator build and run for the PMP testbench

VERILATOR ?= verilator
TOP       ?= riscv_pmp_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
